// ==== gamePkg.sv ====
// constants and shared types for the falling-tower path
// positions are signed fixed point in 1/64 pixel, so a tower can sit above the screen
// colours are RGB332 (rrr ggg bb)
// SPAWN_MARGIN plus the LFSR column slice has to keep a whole tower on screen

package gamePkg;

	typedef logic [10:0] pixelCoord_t; // screen coordinate or offset
	typedef logic signed [31:0] fixedPos_t;
	typedef logic [7:0] rgb_t;
	typedef logic [15:0] lfsr_t;

	typedef struct packed {
		pixelCoord_t x;
		pixelCoord_t y;
	} pixelPos_t;

	typedef struct packed {
		logic hit;
		pixelCoord_t offsetX; // from the tower's top left corner
		pixelCoord_t offsetY;
	} towerHit_t;

	typedef struct packed {
		logic opaque;
		rgb_t color;
	} shapePix_t;

	localparam int SCREEN_W = 640;
	localparam int SCREEN_H = 480;
	localparam int GROUND_Y = 440; // first row of the ground band

	localparam int TOWER_W = 28;
	localparam int TOWER_H = 58;
	localparam int BATTLEMENT_H = 6; // rows of the crenellated top
	localparam int CRENEL_BIT = 2; // offsetX bit that cuts a gap, 4 pixel teeth
	localparam int WINDOW_TOP = 20;
	localparam int WINDOW_BOTTOM = 28; // exclusive
	localparam int WINDOW_LEFT = 10;
	localparam int WINDOW_RIGHT = 18; // exclusive

	localparam int FIXED_MUL = 64; // fixed point units per pixel
	localparam int FIXED_SHIFT = $clog2(FIXED_MUL);
	localparam int FALL_SPEED = 100; // units per frame
	localparam int MAX_TOWERS = 10;
	localparam int TOWERS_WAIT = 100; // frames between added towers

	typedef logic [$clog2(MAX_TOWERS + 1) - 1:0] towerCount_t;
	typedef logic [$clog2(TOWERS_WAIT + 1) - 1:0] frameTimer_t;

	// below the screen, so a tower respawns on its first active frame
	localparam fixedPos_t PARKED_Y = (SCREEN_H + 1) * FIXED_MUL;

	localparam int SPAWN_MARGIN = 64;
	// column slice sized to the playfield between the two margins
	localparam int SPAWN_BITS = $clog2(SCREEN_W - TOWER_W - 2 * SPAWN_MARGIN);
	localparam lfsr_t LFSR_SEED = 16'hACE1;
	localparam lfsr_t LFSR_TAPS = 16'hB400;

	localparam rgb_t SKY_COLOR = 8'h5F; // light blue
	localparam rgb_t GROUND_COLOR = 8'h8C; // brown
	localparam rgb_t WALL_COLOR = 8'h92; // stone grey
	localparam rgb_t WINDOW_COLOR = 8'hFC; // lit yellow

endpackage

// ==== spawnPosition.sv ====
// one LFSR step per frame, so towers that respawn in the same frame share a column
// the column runs from SPAWN_MARGIN to SPAWN_MARGIN + 2**SPAWN_BITS - 1
// spawnX follows the register directly, the field samples it before the step

module spawnPosition (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	output gamePkg::pixelCoord_t spawnX
);

	gamePkg::lfsr_t lfsr;
	gamePkg::lfsr_t lfsrNext;
	gamePkg::pixelCoord_t column; // low LFSR bits, zero extended

	// right shifting Galois form, taps go in when a one drops out
	always_comb begin
		lfsrNext = lfsr >> 1;
		if (lfsr[0]) begin
			lfsrNext = lfsrNext ^ gamePkg::LFSR_TAPS;
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lfsr <= gamePkg::LFSR_SEED;
		end else if (startOfFrame) begin
			lfsr <= lfsrNext;
		end
	end

	assign column = gamePkg::pixelCoord_t'(lfsr[gamePkg::SPAWN_BITS - 1:0]);

	// shift past the left margin
	assign spawnX = column + gamePkg::pixelCoord_t'(gamePkg::SPAWN_MARGIN);

endmodule

// ==== towerField.sv ====
// holds up to MAX_TOWERS falling towers, updated once per frame on startOfFrame
// only towers below the active count move or draw; the rest stay parked
// the hit test sees the positions from before the frame edge
// hit is one register after the pixel; on overlap the highest index tower wins

module towerField (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic pause,
	input gamePkg::pixelPos_t pixel,
	input gamePkg::pixelCoord_t spawnX,
	output gamePkg::towerHit_t hit
);

	gamePkg::fixedPos_t posX [gamePkg::MAX_TOWERS]; // top left corners
	gamePkg::fixedPos_t posY [gamePkg::MAX_TOWERS];
	gamePkg::towerCount_t towerCount; // active towers
	gamePkg::frameTimer_t addTimer; // frames left until the next tower
	gamePkg::fixedPos_t fallStep;
	gamePkg::fixedPos_t spawnFixed;
	gamePkg::towerHit_t hitNext;

	// pause freezes the fall but not the add timer
	assign fallStep = pause ? gamePkg::fixedPos_t'(0)
		: gamePkg::fixedPos_t'(gamePkg::FALL_SPEED);

	assign spawnFixed = gamePkg::fixedPos_t'(spawnX) * gamePkg::FIXED_MUL;

	// tower count and add timer
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			towerCount <= gamePkg::towerCount_t'(1);
			addTimer <= gamePkg::frameTimer_t'(gamePkg::TOWERS_WAIT);
		end else if (startOfFrame) begin
			if (addTimer != '0) begin
				addTimer <= addTimer - 1'b1;
			end else begin
				addTimer <= gamePkg::frameTimer_t'(gamePkg::TOWERS_WAIT);
				if (towerCount < gamePkg::MAX_TOWERS) begin
					towerCount <= towerCount + 1'b1; // saturates at MAX_TOWERS
				end
			end
		end
	end

	// falling and respawn
	// a new tower only becomes active after the count edge, and it is still
	// parked below the screen, so it respawns on its first active frame
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int i = 0; i < gamePkg::MAX_TOWERS; i++) begin
				posX[i] <= '0;
				posY[i] <= gamePkg::PARKED_Y;
			end
		end else if (startOfFrame) begin
			for (int i = 0; i < gamePkg::MAX_TOWERS; i++) begin
				if (i < towerCount) begin
					if (posY[i] > gamePkg::SCREEN_H * gamePkg::FIXED_MUL) begin
						posY[i] <= -gamePkg::TOWER_H * gamePkg::FIXED_MUL; // just above the top
						posX[i] <= spawnFixed;
					end else begin
						posY[i] <= posY[i] + fallStep;
					end
				end
			end
		end
	end

	// per pixel test against every active tower
	always_comb begin : hitTest
		gamePkg::fixedPos_t px;
		gamePkg::fixedPos_t py;
		gamePkg::fixedPos_t tx;
		gamePkg::fixedPos_t ty;

		px = gamePkg::fixedPos_t'(pixel.x);
		py = gamePkg::fixedPos_t'(pixel.y);
		hitNext = '0;
		for (int i = 0; i < gamePkg::MAX_TOWERS; i++) begin
			// arithmetic shift rounds toward minus infinity, needed above the screen
			tx = posX[i] >>> gamePkg::FIXED_SHIFT;
			ty = posY[i] >>> gamePkg::FIXED_SHIFT;
			if ((i < towerCount)
					&& (px >= tx) && (px < tx + gamePkg::TOWER_W)
					&& (py >= ty) && (py < ty + gamePkg::TOWER_H)) begin
				hitNext.hit = 1'b1; // later index overrides earlier
				hitNext.offsetX = gamePkg::pixelCoord_t'(px - tx);
				hitNext.offsetY = gamePkg::pixelCoord_t'(py - ty);
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hit <= '0;
		end else begin
			hit <= hitNext;
		end
	end

endmodule

// ==== towerShape.sv ====
// draws one tower from its offset: wall, a lit window and crenellated top
// crenel gaps are transparent so the background shows through
// one register stage; offsets are only meaningful while hit is set

module towerShape (
	input logic clk,
	input logic resetN,
	input gamePkg::towerHit_t hit,
	output gamePkg::shapePix_t shape
);

	logic inBattlements;
	logic crenelGap;
	logic windowRows;
	logic windowCols;
	logic inWindow;
	gamePkg::shapePix_t shapeNext;

	assign inBattlements = hit.offsetY < gamePkg::BATTLEMENT_H; // top band
	assign crenelGap = inBattlements && hit.offsetX[gamePkg::CRENEL_BIT];

	assign windowRows = (hit.offsetY >= gamePkg::WINDOW_TOP)
		&& (hit.offsetY < gamePkg::WINDOW_BOTTOM);
	assign windowCols = (hit.offsetX >= gamePkg::WINDOW_LEFT)
		&& (hit.offsetX < gamePkg::WINDOW_RIGHT);
	assign inWindow = windowRows && windowCols;

	always_comb begin
		shapeNext.opaque = hit.hit && !crenelGap;
		if (inWindow) begin
			shapeNext.color = gamePkg::WINDOW_COLOR;
		end else begin
			shapeNext.color = gamePkg::WALL_COLOR;
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			shape <= '0;
		end else begin
			shape <= shapeNext;
		end
	end

endmodule

// ==== pixelMux.sv ====
// puts the tower over the sky or ground band
// pixelY is delayed two stages here to line up with the field and shape registers
// towerPixel is high only when the shown colour comes from a tower

module pixelMux (
	input logic clk,
	input logic resetN,
	input gamePkg::pixelCoord_t pixelY,
	input gamePkg::shapePix_t shape,
	output gamePkg::rgb_t rgb,
	output logic towerPixel
);

	gamePkg::pixelCoord_t yStage1; // aligned with the field output
	gamePkg::pixelCoord_t yStage2; // aligned with shape
	gamePkg::rgb_t background;

	assign background = (yStage2 >= gamePkg::GROUND_Y) ? gamePkg::GROUND_COLOR
		: gamePkg::SKY_COLOR;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			yStage1 <= '0;
			yStage2 <= '0;
			rgb <= gamePkg::SKY_COLOR;
			towerPixel <= 1'b0;
		end else begin
			yStage1 <= pixelY;
			yStage2 <= yStage1;
			rgb <= shape.opaque ? shape.color : background;
			towerPixel <= shape.opaque;
		end
	end

endmodule

// ==== towerSceneTop.sv ====
// falling-tower object path, pixel in and colour out
// three register stages: a pixel in cycle n shows on rgb after the edge ending cycle n+2
// the VGA counters and startOfFrame come from outside; a new pixel may enter every cycle

module towerSceneTop (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic pause,
	input gamePkg::pixelPos_t pixel,
	output gamePkg::rgb_t rgb,
	output logic towerPixel
);

	gamePkg::pixelCoord_t spawnX;
	gamePkg::towerHit_t hit;
	gamePkg::shapePix_t shape;

	spawnPosition u_spawnPosition (
		.clk (clk),
		.resetN (resetN),
		.startOfFrame (startOfFrame),
		.spawnX (spawnX)
	);

	towerField u_towerField (
		.clk (clk),
		.resetN (resetN),
		.startOfFrame (startOfFrame),
		.pause (pause),
		.pixel (pixel),
		.spawnX (spawnX),
		.hit (hit)
	);

	towerShape u_towerShape (
		.clk (clk),
		.resetN (resetN),
		.hit (hit),
		.shape (shape)
	);

	// y goes in undelayed, the mux holds its own pipeline copy
	pixelMux u_pixelMux (
		.clk (clk),
		.resetN (resetN),
		.pixelY (pixel.y),
		.shape (shape),
		.rgb (rgb),
		.towerPixel (towerPixel)
	);

endmodule

// ==== towerSceneTb.sv ====
// directed testbench for towerSceneTop with a frame level reference model
// the model follows the game rules and steps on every frame pulse that the bench issues
// a frame is one cycle long here, and only tower 0 is active until frame 101
// a probe is due 3 edges after its pixel is driven and outputs are sampled 1 ns after the edge

module towerSceneTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_HALF = 50;
	localparam int DRIVE_DELAY = 5; // ns after the rising edge
	localparam int LATENCY = 3;
	localparam int DRAIN_LIMIT = 10; // cycles

	logic clk;
	logic resetN;
	logic startOfFrame;
	logic pause;
	gamePkg::pixelPos_t pixel;
	gamePkg::rgb_t rgb;
	logic towerPixel;

	// reference model
	int modelX [gamePkg::MAX_TOWERS]; // fixed point in 1/64 pixel
	int modelY [gamePkg::MAX_TOWERS];
	int modelCount;
	int modelTimer;
	logic [15:0] modelLfsr;
	int respawns0; // spawns of tower 0 including the first

	// probes in flight with the oldest first
	gamePkg::rgb_t expRgbQ [$];
	logic expFlagQ [$];
	int dueQ [$];
	string labelQ [$];

	int cycleCount;
	int checkCount;
	int errorCount;
	int testStartErrors;
	logic [31:0] rngState;

	towerSceneTop u_towerSceneTop (
		.clk (clk),
		.resetN (resetN),
		.startOfFrame (startOfFrame),
		.pause (pause),
		.pixel (pixel),
		.rgb (rgb),
		.towerPixel (towerPixel)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_HALF) clk = ~clk;
	end

	function automatic logic [31:0] nextRandom();
		logic [31:0] s;
		s = rngState;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rngState = s;
		return s;
	endfunction

	// fixed point to pixel rounded toward minus infinity
	function automatic int floorPixel(input int pos);
		if (pos >= 0) begin
			return pos / gamePkg::FIXED_MUL;
		end
		return -((-pos + gamePkg::FIXED_MUL - 1) / gamePkg::FIXED_MUL);
	endfunction

	function automatic void expectPixel(input int x, input int y, output gamePkg::rgb_t color,
			output logic isTower);
		logic covered;
		int ox;
		int oy;
		int tx;
		int ty;
		covered = 1'b0;
		ox = 0;
		oy = 0;
		for (int i = 0; i < modelCount; i++) begin
			tx = floorPixel(modelX[i]);
			ty = floorPixel(modelY[i]);
			if (x >= tx && x < tx + gamePkg::TOWER_W && y >= ty && y < ty + gamePkg::TOWER_H) begin
				covered = 1'b1; // a later tower wins
				ox = x - tx;
				oy = y - ty;
			end
		end
		isTower = covered && !(oy < 6 && ox[2]); // crenel gaps are see-through
		if (isTower && oy >= 20 && oy < 28 && ox >= 10 && ox < 18) begin
			color = gamePkg::WINDOW_COLOR;
		end else if (isTower) begin
			color = gamePkg::WALL_COLOR;
		end else if (y >= gamePkg::GROUND_Y) begin
			color = gamePkg::GROUND_COLOR;
		end else begin
			color = gamePkg::SKY_COLOR;
		end
	endfunction

	task automatic modelReset();
		for (int i = 0; i < gamePkg::MAX_TOWERS; i++) begin
			modelX[i] = 0;
			modelY[i] = (gamePkg::SCREEN_H + 1) * gamePkg::FIXED_MUL; // parked below
		end
		modelCount = 1;
		modelTimer = gamePkg::TOWERS_WAIT;
		modelLfsr = gamePkg::LFSR_SEED;
		respawns0 = 0;
	endtask

	task automatic modelFrame();
		int spawnX;
		logic dropped;
		spawnX = gamePkg::SPAWN_MARGIN + int'(modelLfsr & 16'h01FF);
		for (int i = 0; i < modelCount; i++) begin
			if (modelY[i] > gamePkg::SCREEN_H * gamePkg::FIXED_MUL) begin
				modelY[i] = -gamePkg::TOWER_H * gamePkg::FIXED_MUL;
				modelX[i] = spawnX * gamePkg::FIXED_MUL;
				if (i == 0) begin
					respawns0++;
				end
			end else if (!pause) begin
				modelY[i] = modelY[i] + gamePkg::FALL_SPEED;
			end
		end
		// the timer runs through pause
		if (modelTimer == 0) begin
			modelTimer = gamePkg::TOWERS_WAIT;
			if (modelCount < gamePkg::MAX_TOWERS) begin
				modelCount++;
			end
		end else begin
			modelTimer--;
		end
		dropped = modelLfsr[0];
		modelLfsr = modelLfsr >> 1;
		if (dropped) begin
			modelLfsr = modelLfsr ^ gamePkg::LFSR_TAPS;
		end
	endtask

	task automatic checkRgb(input gamePkg::rgb_t got, input gamePkg::rgb_t expected,
			input string what);
		checkCount++;
		if (got !== expected) begin
			$display("Fail %0t ns: %s, rgb %h expected %h", $time, what, got, expected);
			errorCount++;
		end
	endtask

	task automatic checkFlag(input logic got, input logic expected, input string what);
		checkCount++;
		if (got !== expected) begin
			$display("Fail %0t ns: %s, towerPixel %b expected %b", $time, what, got, expected);
			errorCount++;
		end
	endtask

	// one clock that checks any probe due and returns at the drive point
	task automatic tick();
		@(posedge clk);
		cycleCount++;
		#1;
		if (dueQ.size() > 0 && dueQ[0] == cycleCount) begin
			checkRgb(rgb, expRgbQ[0], labelQ[0]);
			checkFlag(towerPixel, expFlagQ[0], labelQ[0]);
			void'(dueQ.pop_front());
			void'(expRgbQ.pop_front());
			void'(expFlagQ.pop_front());
			void'(labelQ.pop_front());
		end
		#(DRIVE_DELAY - 1);
	endtask

	task automatic sendPixel(input int x, input int y, input string label);
		gamePkg::rgb_t color;
		logic isTower;
		expectPixel(x, y, color, isTower);
		pixel.x = gamePkg::pixelCoord_t'(x);
		pixel.y = gamePkg::pixelCoord_t'(y);
		expRgbQ.push_back(color);
		expFlagQ.push_back(isTower);
		labelQ.push_back($sformatf("%s at (%0d,%0d)", label, x, y));
		dueQ.push_back(cycleCount + LATENCY);
		tick();
	endtask

	task automatic sendIfVisible(input int x, input int y, input string label);
		if (x >= 0 && x < gamePkg::SCREEN_W && y >= 0 && y < gamePkg::SCREEN_H) begin
			sendPixel(x, y, label);
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (dueQ.size() > 0 && waited < DRAIN_LIMIT) begin
			tick();
			waited++;
		end
		if (dueQ.size() > 0) begin
			$display("timeout: %0d probe results never came out of the DUT", dueQ.size());
			errorCount++;
			dueQ.delete();
			expRgbQ.delete();
			expFlagQ.delete();
			labelQ.delete();
		end
	endtask

	task automatic frame();
		startOfFrame = 1'b1;
		modelFrame();
		tick();
		startOfFrame = 1'b0;
	endtask

	task automatic waitTowerRow(input int idx, input int row, input int limit, input string what);
		int frames;
		frames = 0;
		while (floorPixel(modelY[idx]) < row && frames < limit) begin
			frame();
			frames++;
		end
		if (floorPixel(modelY[idx]) < row) begin
			$display("timeout: %s, tower %0d not down to row %0d after %0d frames",
				what, idx, row, frames);
			errorCount++;
		end
	endtask

	// edges, window, crenels and the rows around one tower
	task automatic probeTower(input int idx, input string label);
		int offX [16] = '{0, 27, 28, -1, 14, 9, 17, 18, 0, 4, 7, 8, 4, 10, 10, 10};
		int offY [16] = '{30, 30, 30, 30, 24, 24, 27, 27, 0, 0, 5, 5, 6, 57, 58, -1};
		int tx;
		int ty;
		tx = floorPixel(modelX[idx]);
		ty = floorPixel(modelY[idx]);
		for (int k = 0; k < 16; k++) begin
			sendIfVisible(tx + offX[k], ty + offY[k], label);
		end
		drain();
	endtask

	task automatic probeEdges(input int idx, input string label);
		int tx;
		int ty;
		tx = floorPixel(modelX[idx]);
		ty = floorPixel(modelY[idx]) + 30;
		sendIfVisible(tx - 1, ty, label);
		sendIfVisible(tx, ty, label);
		sendIfVisible(tx + 27, ty, label);
		sendIfVisible(tx + 28, ty, label);
	endtask

	// probe checked against the model and then against a fixed colour
	task automatic probeLiteral(input int x, input int y, input gamePkg::rgb_t color,
			input logic isTower, input string label);
		sendPixel(x, y, label);
		drain();
		checkRgb(rgb, color, label);
		checkFlag(towerPixel, isTower, label);
	endtask

	task automatic endTest(input string name);
		if (errorCount == testStartErrors) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: %0d errors", name, errorCount - testStartErrors);
		end
	endtask

	task automatic testReset();
		testStartErrors = errorCount;
		checkRgb(rgb, gamePkg::SKY_COLOR, "reset value");
		checkFlag(towerPixel, 1'b0, "reset value");
		probeLiteral(100, 100, gamePkg::SKY_COLOR, 1'b0, "sky");
		probeLiteral(600, 439, gamePkg::SKY_COLOR, 1'b0, "last sky row");
		probeLiteral(0, 440, gamePkg::GROUND_COLOR, 1'b0, "first ground row");
		probeLiteral(639, 479, gamePkg::GROUND_COLOR, 1'b0, "ground corner");
		endTest("after reset");
	endtask

	task automatic testFall();
		testStartErrors = errorCount;
		frame(); // first spawn is still above the screen
		probeTower(0, "spawned");
		waitTowerRow(0, -30, 40, "entering the screen");
		probeTower(0, "entering");
		waitTowerRow(0, 40, 80, "falling");
		probeTower(0, "falling");
		endTest("spawn and fall");
	endtask

	task automatic testPause();
		int tx;
		int ty;
		testStartErrors = errorCount;
		tx = floorPixel(modelX[0]);
		ty = floorPixel(modelY[0]);
		probeLiteral(tx + 14, ty + 24, gamePkg::WINDOW_COLOR, 1'b1, "window before pause");
		probeLiteral(tx, ty, gamePkg::WALL_COLOR, 1'b1, "corner before pause");
		pause = 1'b1;
		for (int k = 0; k < 5; k++) begin
			frame();
			probeLiteral(tx + 14, ty + 24, gamePkg::WINDOW_COLOR, 1'b1, "paused window");
			probeLiteral(tx, ty, gamePkg::WALL_COLOR, 1'b1, "paused corner");
		end
		pause = 1'b0;
		frame();
		frame(); // at least 3 pixels down by now
		probeLiteral(tx, ty, gamePkg::SKY_COLOR, 1'b0, "old corner after resume");
		probeTower(0, "resumed");
		endTest("pause");
	endtask

	task automatic testGrowth();
		int frames;
		int idx;
		testStartErrors = errorCount;
		frames = 0;
		while ((modelCount < 4 || respawns0 < 2) && frames < 1000) begin
			frame();
			frames++;
			probeEdges(modelCount - 1, "newest tower");
			idx = int'(nextRandom() % modelCount);
			probeEdges(idx, "random tower");
			sendPixel(int'(nextRandom() % gamePkg::SCREEN_W),
				int'(nextRandom() % gamePkg::SCREEN_H), "random pixel");
			sendPixel(int'(nextRandom() % gamePkg::SCREEN_W),
				int'(nextRandom() % gamePkg::SCREEN_H), "random pixel");
			drain();
		end
		if (modelCount < 4 || respawns0 < 2) begin
			$display("timeout: towers did not grow and respawn within %0d frames", frames);
			errorCount++;
		end else begin
			// tower 0 fell off the bottom and came back at a new column
			waitTowerRow(0, 0, 60, "respawned tower entering");
			probeTower(0, "respawned");
		end
		endTest("growth and respawn");
	endtask

	task automatic testStream();
		int frames;
		int found;
		int tx;
		int ty;
		testStartErrors = errorCount;
		frames = 0;
		found = -1;
		while (found < 0 && frames < 200) begin
			for (int i = 0; i < modelCount; i++) begin
				ty = floorPixel(modelY[i]);
				if (ty >= 0 && ty + 24 < gamePkg::SCREEN_H) begin
					found = i;
				end
			end
			if (found < 0) begin
				frame();
				frames++;
			end
		end
		if (found < 0) begin
			$display("timeout: no tower came into view within %0d frames", frames);
			errorCount++;
		end else begin
			tx = floorPixel(modelX[found]);
			ty = floorPixel(modelY[found]) + 24; // through the window
			for (int x = tx - 4; x < tx + gamePkg::TOWER_W + 4; x++) begin
				sendIfVisible(x, ty, "stream");
			end
			drain();
		end
		endTest("streaming");
	endtask

	initial begin
		resetN = 1'b0;
		startOfFrame = 1'b0;
		pause = 1'b0;
		pixel = '0;
		cycleCount = 0;
		checkCount = 0;
		errorCount = 0;
		rngState = 32'h2297;
		modelReset();
		for (int k = 0; k < 5; k++) begin
			tick();
		end
		resetN = 1'b1;
		testReset();
		testFall();
		testPause();
		testGrowth();
		testStream();
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== build.f ====
gamePkg.sv
spawnPosition.sv
towerField.sv
towerShape.sv
pixelMux.sv
towerSceneTop.sv
towerSceneTb.sv
